/* common/heapPkg.sv */
// Heap geometry and the typedefs built on it
// Command and error encodings
// Command and response structs
package heapPkg;

  // ------------------------------------------------------------------------
  // Geometry
  // ------------------------------------------------------------------------
  localparam int addressBits = 3;                    // Bits in an array number
  localparam int indexBits   = 2;                    // Bits in an element index
  localparam int dataBits    = 16;                   // Element width
  localparam int arrayLength = 1 << indexBits;       // Elements per array
  localparam int arrayCount  = 1 << addressBits;     // Arrays in the heap

  typedef logic [addressBits-1:0] arrayNum_t;        // Array number
  typedef logic [indexBits-1:0]   index_t;           // Element index
  typedef logic [indexBits:0]     size_t;            // Size 0 to arrayLength
  typedef logic [dataBits-1:0]    data_t;            // Element value

  // ------------------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------------------
  typedef enum logic [7:0] {
    actNone     = 8'd0,                              // Idle
    actWrite    = 8'd2,                              // Write an element
    actRead     = 8'd3,                              // Read an element
    actSize     = 8'd4,                              // Size of an array
    actPush     = 8'd14,                             // Append to the end
    actPop      = 8'd15,                             // Remove from the end
    actAlloc    = 8'd18,                             // Claim an array number
    actFree     = 8'd19,                             // Return an array number
    actAdd      = 8'd20,                             // Add, new value out
    actAddAfter = 8'd21,                             // Add, old value out
    actSub      = 8'd22,                             // Subtract, new value out
    actSubAfter = 8'd23,                             // Subtract, old value out
    actOr       = 8'd28,
    actXor      = 8'd29,
    actAnd      = 8'd30
  } heapAction_t;

  typedef enum logic [3:0] {
    errNone         = 4'd0,
    errNotAllocated = 4'd1,                          // Number never issued
    errFreed        = 4'd2,                          // Issued but freed since
    errOutOfBounds  = 4'd3,                          // Index at or past size
    errFull         = 4'd4,                          // Push with no room
    errEmpty        = 4'd5,                          // Pop with nothing left
    errOutOfMemory  = 4'd6                           // No number to allocate
  } heapError_t;

  typedef struct packed {
    heapAction_t action;
    arrayNum_t   array;
    index_t      index;
    data_t       data;                               // Operand or value to store
  } heapCmd_t;

  typedef struct packed {
    data_t      out;                                 // Result of the last data command
    heapError_t error;                               // Check result of the last command
  } heapRsp_t;

endpackage

/* hw/alloc/arrayAllocator.sv */
// Array number allocation
// Issue counter, live flags and the stack of freed numbers
`timescale 1ns/1ps

module arrayAllocator #(
  parameter int maxArrays = 7                          // Fresh numbers that may be issued
) (
  input  logic               clock,
  input  logic               reset,
  input  heapPkg::arrayNum_t array,                    // Array addressed by the command
  input  logic               allocStrobe,
  input  logic               freeStrobe,
  output logic               issued,
  output logic               live,
  output heapPkg::arrayNum_t freeArray,                // Number the next alloc returns
  output logic               canAlloc
);
  import heapPkg::*;

  logic [addressBits:0]   issuedCount;                 // Numbers handed out fresh so far
  logic [arrayCount-1:0]  liveFlags;                   // One per array
  arrayNum_t              freeStack [arrayCount];      // Freed numbers, reused first
  logic [addressBits:0]   stackTop;                    // Entries on the stack
  logic                   stackEmpty;
  arrayNum_t              topEntry;                    // Most recently freed number

  assign stackEmpty = stackTop == '0;
  assign topEntry   = freeStack[arrayNum_t'(stackTop - 1'b1)];

  assign issued    = {1'b0, array} < issuedCount;
  assign live      = liveFlags[array];
  assign freeArray = stackEmpty ? issuedCount[addressBits-1:0] : topEntry;
  assign canAlloc  = !stackEmpty || issuedCount < maxArrays;

  // Counter, flags and stack pointer
  always_ff @(posedge clock) begin
    if (reset) begin
      issuedCount <= '0;
      liveFlags   <= '0;
      stackTop    <= '0;
    end else if (allocStrobe) begin
      liveFlags[freeArray] <= 1'b1;
      if (stackEmpty) issuedCount <= issuedCount + 1'b1;   // Fresh number
      else stackTop <= stackTop - 1'b1;                   // Reuse freed number
    end else if (freeStrobe) begin
      liveFlags[array] <= 1'b0;
      stackTop         <= stackTop + 1'b1;
    end
  end

  // Stack contents
  always_ff @(posedge clock) begin
    if (freeStrobe) begin
      freeStack[arrayNum_t'(stackTop)] <= array;       // Only live arrays get here
    end
  end

endmodule

/* hw/alloc/sizeTable.sv */
// Current size of every array
// Cleared on alloc, rewritten by write, push and pop
`timescale 1ns/1ps

module sizeTable (
  input  logic               clock,
  input  logic               reset,
  input  heapPkg::arrayNum_t array,                    // Array addressed by the command
  input  heapPkg::arrayNum_t freeArray,                // Array being allocated
  input  logic               allocStrobe,
  input  logic               sizeWrite,
  input  heapPkg::size_t     newSize,
  output heapPkg::size_t     arraySize
);
  import heapPkg::*;

  size_t sizes [arrayCount];                           // One size per array

  assign arraySize = sizes[array];                     // Seen by the same command

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else if (allocStrobe) begin
      sizes[freeArray] <= '0;                          // New array starts empty
    end else if (sizeWrite) begin
      sizes[array] <= newSize;
    end
  end

endmodule

/* hw/store/elementAlu.sv */
// Element arithmetic and logic for write, push and in-place commands
`timescale 1ns/1ps

module elementAlu (
  input  heapPkg::heapAction_t op,
  input  heapPkg::data_t       oldValue,               // Element as stored
  input  heapPkg::data_t       data,                   // Command operand
  output heapPkg::data_t       newValue                // Value to store back
);
  import heapPkg::*;

  always_comb begin
    case (op)
      actWrite, actPush:   newValue = data;            // Plain store
      actAdd, actAddAfter: newValue = oldValue + data; // Wraps at 16 bits
      actSub, actSubAfter: newValue = oldValue - data;
      actOr:               newValue = oldValue | data;
      actXor:              newValue = oldValue ^ data;
      actAnd:              newValue = oldValue & data;
      default:             newValue = oldValue;        // No change
    endcase
  end

endmodule

/* hw/store/elementStore.sv */
// Element memory for all arrays
// One combinational read port and one write port on the same slot
`timescale 1ns/1ps

module elementStore (
  input  logic                 clock,
  input  heapPkg::arrayNum_t   array,                  // Array addressed by the command
  input  heapPkg::index_t      elemIndex,              // Slot chosen by the decoder
  input  heapPkg::heapAction_t elemOp,
  input  logic                 elemWrite,
  input  heapPkg::data_t       data,                   // Command operand
  output heapPkg::data_t       oldValue,
  output heapPkg::data_t       newValue
);
  import heapPkg::*;

  data_t memory [arrayCount][arrayLength];             // Fixed block per array

  // ------------------------------------------------------------------------
  // Read-modify-write path
  // ------------------------------------------------------------------------
  assign oldValue = memory[array][elemIndex];

  elementAlu alu (
    .op       (elemOp),
    .oldValue (oldValue),
    .data     (data),
    .newValue (newValue)
  );

  always_ff @(posedge clock) begin
    if (elemWrite) begin
      memory[array][elemIndex] <= newValue;            // Seen by the next command
    end
  end

endmodule

/* hw/commandDecode.sv */
// Command checks against the heap state
// Update strobes to allocator, size table and element store
// Registered response
`timescale 1ns/1ps

module commandDecode (
  input  logic                 clock,
  input  logic                 reset,
  input  heapPkg::heapCmd_t    cmd,
  input  logic                 issued,
  input  logic                 live,
  input  heapPkg::arrayNum_t   freeArray,
  input  logic                 canAlloc,
  input  heapPkg::size_t       arraySize,
  input  heapPkg::data_t       oldValue,
  input  heapPkg::data_t       newValue,
  output logic                 allocStrobe,
  output logic                 freeStrobe,
  output logic                 sizeWrite,
  output heapPkg::size_t       newSize,
  output logic                 elemWrite,
  output heapPkg::index_t      elemIndex,
  output heapPkg::heapAction_t elemOp,
  output heapPkg::heapRsp_t    rsp
);
  import heapPkg::*;

  heapError_t result;                                  // Check outcome
  data_t      outValue;                                // Candidate for rsp.out
  logic       returnsData;                             // Command updates rsp.out
  logic       inPlace;                                   // Read-modify-write commands
  logic       inBounds;                                // Index below current size
  logic       ok;                                      // Command passed every check

  assign inPlace  = cmd.action inside {actAdd, actAddAfter, actSub, actSubAfter,
                                       actOr, actXor, actAnd};
  assign inBounds = size_t'(cmd.index) < arraySize;
  assign ok       = cmd.action != actNone && result == errNone;
  assign elemOp   = cmd.action;                        // ALU picks its function from it

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  always_comb begin
    result = errNone;
    if (cmd.action == actAlloc) begin
      if (!canAlloc) result = errOutOfMemory;
    end else if (cmd.action != actNone) begin
      if (!issued) result = errNotAllocated;
      else if (!live) result = errFreed;             // Also catches a double free
      else if ((cmd.action == actRead || inPlace) && !inBounds) result = errOutOfBounds;
      else if (cmd.action == actPush && arraySize == size_t'(arrayLength)) result = errFull;
      else if (cmd.action == actPop && arraySize == '0) result = errEmpty;
    end
  end

  // ------------------------------------------------------------------------
  // Strobes
  // ------------------------------------------------------------------------
  always_comb begin
    allocStrobe = ok && cmd.action == actAlloc;
    freeStrobe  = ok && cmd.action == actFree;
    elemIndex   = cmd.index;
    elemWrite   = 1'b0;
    sizeWrite   = 1'b0;
    newSize     = arraySize;
    case (cmd.action)
      actWrite: begin
        elemWrite = ok;
        sizeWrite = ok && !inBounds;                   // Grow to cover the index
        newSize   = size_t'(cmd.index) + size_t'(1);
      end
      actPush: begin
        elemIndex = arraySize[indexBits-1:0];          // First empty slot
        elemWrite = ok;
        sizeWrite = ok;
        newSize   = arraySize + size_t'(1);
      end
      actPop: begin
        newSize   = arraySize - size_t'(1);
        elemIndex = newSize[indexBits-1:0];            // Last occupied slot
        sizeWrite = ok;
      end
      default: elemWrite = ok && inPlace;
    endcase
  end

  // ------------------------------------------------------------------------
  // Response
  // ------------------------------------------------------------------------
  always_comb begin
    outValue    = oldValue;
    returnsData = 1'b1;
    case (cmd.action)
      actRead, actPop, actAddAfter, actSubAfter: outValue = oldValue;
      actAdd, actSub, actOr, actXor, actAnd:     outValue = newValue;
      actSize:  outValue = data_t'(arraySize);
      actWrite: outValue = cmd.data;                   // Echo of the stored value
      actAlloc: outValue = data_t'(freeArray);         // Number just handed out
      default:  returnsData = 1'b0;                    // Push, free, idle
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rsp.out   <= '0;
      rsp.error <= errNone;
    end else if (cmd.action != actNone) begin
      rsp.error <= result;
      if (ok && returnsData) rsp.out <= outValue;      // Failed commands keep the old data
    end
  end

endmodule

/* hw/heapTop.sv */
// Heap top level
// Decoder, allocator, size table and element store
`timescale 1ns/1ps

module heapTop #(
  parameter int maxArrays = 7                          // Limit on fresh allocations
) (
  input  logic              clock,
  input  logic              reset,
  input  heapPkg::heapCmd_t cmd,                       // One command per cycle
  output heapPkg::heapRsp_t rsp                        // Valid one cycle later
);
  import heapPkg::*;

  logic        issued;                                 // Addressed array was ever issued
  logic        live;                                   // Addressed array not freed
  arrayNum_t   freeArray;                              // Next number to hand out
  logic        canAlloc;
  size_t       arraySize;                              // Size of addressed array
  data_t       oldValue;                               // Element before the update
  data_t       newValue;                               // Element after the update
  logic        allocStrobe;
  logic        freeStrobe;
  logic        sizeWrite;
  size_t       newSize;
  logic        elemWrite;
  index_t      elemIndex;                              // Element slot for this command
  heapAction_t elemOp;

  commandDecode decode (
    .clock       (clock),
    .reset       (reset),
    .cmd         (cmd),
    .issued      (issued),
    .live        (live),
    .freeArray   (freeArray),
    .canAlloc    (canAlloc),
    .arraySize   (arraySize),
    .oldValue    (oldValue),
    .newValue    (newValue),
    .allocStrobe (allocStrobe),
    .freeStrobe  (freeStrobe),
    .sizeWrite   (sizeWrite),
    .newSize     (newSize),
    .elemWrite   (elemWrite),
    .elemIndex   (elemIndex),
    .elemOp      (elemOp),
    .rsp         (rsp)
  );

  arrayAllocator #(.maxArrays(maxArrays)) allocator (
    .clock       (clock),
    .reset       (reset),
    .array       (cmd.array),
    .allocStrobe (allocStrobe),
    .freeStrobe  (freeStrobe),
    .issued      (issued),
    .live        (live),
    .freeArray   (freeArray),
    .canAlloc    (canAlloc)
  );

  sizeTable sizes (
    .clock       (clock),
    .reset       (reset),
    .array       (cmd.array),
    .freeArray   (freeArray),
    .allocStrobe (allocStrobe),
    .sizeWrite   (sizeWrite),
    .newSize     (newSize),
    .arraySize   (arraySize)
  );

  elementStore store (
    .clock     (clock),
    .array     (cmd.array),
    .elemIndex (elemIndex),
    .elemOp    (elemOp),
    .elemWrite (elemWrite),
    .data      (cmd.data),
    .oldValue  (oldValue),
    .newValue  (newValue)
  );

endmodule

/* sim/heapTests.svh */
// Directed heap tests, one task per behavior
// Expected results come from the command rules
`ifndef HEAP_TESTS_SVH
`define HEAP_TESTS_SVH

  // Element value after an in-place command
  function automatic data_t applyOp(input heapAction_t op, input data_t a, input data_t b);
    case (op)
      actAdd, actAddAfter: return a + b;               // 16-bit wrap
      actSub, actSubAfter: return a - b;
      actOr:               return a | b;
      actXor:              return a ^ b;
      default:             return a & b;
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Allocation order, reuse and exhaustion
  // --------------------------------------------------------------------------
  task automatic testAllocation();
    checkData("after reset", rsp.out, '0);
    checkError("after reset", rsp.error, errNone);
    for (int i = 0; i < 3; i++) begin
      runCmd(actAlloc, '0, '0, '0);
      checkError("alloc", rsp.error, errNone);
      checkData("alloc", rsp.out, data_t'(i));         // Fresh numbers in order
    end
    runCmd(actFree, 3'd1, '0, '0);
    checkError("free 1", rsp.error, errNone);
    checkData("free 1", rsp.out, 16'd2);               // Free returns no data
    runCmd(actAlloc, '0, '0, '0);
    checkData("realloc", rsp.out, 16'd1);              // Freed number reused first
    for (int i = 3; i < 7; i++) begin
      runCmd(actAlloc, '0, '0, '0);
      checkData("alloc", rsp.out, data_t'(i));
    end
    runCmd(actAlloc, '0, '0, '0);
    checkError("alloc beyond limit", rsp.error, errOutOfMemory);
    checkData("alloc beyond limit", rsp.out, 16'd6);
  endtask

  // --------------------------------------------------------------------------
  // Write, read and size on array 0
  // --------------------------------------------------------------------------
  task automatic testWriteRead();
    data_t values [4];
    for (int i = 0; i < 4; i++) values[i] = data_t'($random(seed));
    runCmd(actWrite, 3'd0, 2'd2, values[2]);
    checkError("write 2", rsp.error, errNone);
    checkData("write 2", rsp.out, values[2]);          // Write echoes its data
    runCmd(actWrite, 3'd0, 2'd0, values[0]);
    runCmd(actWrite, 3'd0, 2'd1, values[1]);
    runCmd(actSize, 3'd0, '0, '0);
    checkData("size", rsp.out, 16'd3);                 // Highest index plus one
    for (int i = 0; i < 3; i++) begin
      runCmd(actRead, 3'd0, index_t'(i), '0);
      checkError("read", rsp.error, errNone);
      checkData("read", rsp.out, values[i]);
    end
    runCmd(actRead, 3'd0, 2'd3, '0);
    checkError("read past size", rsp.error, errOutOfBounds);
    checkData("read past size", rsp.out, values[2]);
    runCmd(actWrite, 3'd0, 2'd3, values[3]);
    runCmd(actSize, 3'd0, '0, '0);
    checkData("size full", rsp.out, 16'd4);
    runCmd(actRead, 3'd0, 2'd3, '0);
    checkData("read 3", rsp.out, values[3]);
  endtask

  // --------------------------------------------------------------------------
  // Push and pop on array 2
  // --------------------------------------------------------------------------
  task automatic testPushPop();
    data_t pushed [4];
    runCmd(actSize, 3'd2, '0, '0);
    checkData("empty size", rsp.out, 16'd0);
    for (int i = 0; i < 4; i++) begin
      pushed[i] = data_t'($random(seed));
      runCmd(actPush, 3'd2, '0, pushed[i]);
      checkError("push", rsp.error, errNone);
      checkData("push", rsp.out, 16'd0);               // Push returns no data
    end
    runCmd(actPush, 3'd2, '0, 16'hffff);
    checkError("fifth push", rsp.error, errFull);
    for (int i = 3; i >= 0; i--) begin
      runCmd(actPop, 3'd2, '0, '0);
      checkError("pop", rsp.error, errNone);
      checkData("pop", rsp.out, pushed[i]);            // Last in, first out
    end
    runCmd(actPop, 3'd2, '0, '0);
    checkError("pop empty", rsp.error, errEmpty);
    checkData("pop empty", rsp.out, pushed[0]);
  endtask

  // --------------------------------------------------------------------------
  // In-place operations on array 0
  // --------------------------------------------------------------------------
  task automatic testInPlace();
    heapAction_t ops [7];
    heapAction_t op;                                   // Operation under test
    data_t       a;
    data_t       b;
    data_t       result;
    ops = '{actAdd, actAddAfter, actSub, actSubAfter, actOr, actXor, actAnd};
    for (int k = 0; k < 7; k++) begin
      op     = ops[k];
      a      = data_t'($random(seed));
      b      = data_t'($random(seed));
      result = applyOp(op, a, b);
      runCmd(actWrite, 3'd0, index_t'(k), a);
      runCmd(op, 3'd0, index_t'(k), b);
      checkError(op.name(), rsp.error, errNone);
      if (op == actAddAfter || op == actSubAfter) begin
        checkData(op.name(), rsp.out, a);              // Old value out
      end else begin
        checkData(op.name(), rsp.out, result);
      end
      runCmd(actRead, 3'd0, index_t'(k), '0);
      checkData("read after op", rsp.out, result);
    end
    runCmd(actAdd, 3'd2, 2'd0, 16'd1);
    checkError("add on empty array", rsp.error, errOutOfBounds);
  endtask

  // --------------------------------------------------------------------------
  // Never issued and freed arrays
  // --------------------------------------------------------------------------
  task automatic testBadArrays();
    runCmd(actSize, 3'd3, '0, '0);
    checkData("size 3", rsp.out, 16'd0);
    runCmd(actRead, 3'd7, '0, '0);
    checkError("read unissued", rsp.error, errNotAllocated);
    runCmd(actWrite, 3'd7, '0, data_t'($random(seed)));
    checkError("write unissued", rsp.error, errNotAllocated);
    checkData("write unissued", rsp.out, 16'd0);
    runCmd(actFree, 3'd7, '0, '0);
    checkError("free unissued", rsp.error, errNotAllocated);
    runCmd(actWrite, 3'd3, 2'd1, 16'h5a5a);
    checkData("write 3", rsp.out, 16'h5a5a);           // Size of array 3 now 2
    runCmd(actFree, 3'd3, '0, '0);
    checkError("free 3", rsp.error, errNone);
    runCmd(actFree, 3'd3, '0, '0);
    checkError("double free", rsp.error, errFreed);
    runCmd(actWrite, 3'd3, '0, 16'hbeef);
    checkError("write freed", rsp.error, errFreed);
    checkData("write freed", rsp.out, 16'h5a5a);       // Unchanged by failures
    runCmd(actPush, 3'd3, '0, 16'h1234);
    checkError("push freed", rsp.error, errFreed);
    runCmd(actSize, 3'd3, '0, '0);
    checkError("size freed", rsp.error, errFreed);
    checkData("size freed", rsp.out, 16'h5a5a);
  endtask

`endif

/* sim/heapTb.sv */
// Testbench for the heap top level
// Clock, reset, DUT, compare tasks, timeout and final report
`timescale 1ns/1ps

module heapTb;
  import heapPkg::*;

  localparam int cycleLimit = 400;                     // About 65 commands plus reset, wide margin

  logic     clock;
  logic     reset;
  heapCmd_t cmd;
  heapRsp_t rsp;

  int       checkCount;
  int       dataErrors;                                // Wrong rsp.out values
  int       errorErrors;                               // Wrong rsp.error codes
  int       cycleCount;
  integer   seed;                                      // Stimulus seed

  heapTop #(.maxArrays(7)) u_dut (
    .clock (clock),
    .reset (reset),
    .cmd   (cmd),
    .rsp   (rsp)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;                         // 10 ns period
  end

  // --------------------------------------------------------------------------
  // Command driver and compare tasks
  // --------------------------------------------------------------------------
  task automatic runCmd(input heapAction_t action, input arrayNum_t array,
                        input index_t index, input data_t data);
    cmd.action = action;                               // Driven on the falling edge
    cmd.array  = array;
    cmd.index  = index;
    cmd.data   = data;
    @(negedge clock);                                  // Response settled by now
    cmd.action = actNone;
  endtask

  task automatic checkData(input string what, input data_t got, input data_t expected);
    checkCount++;
    if (got !== expected) begin
      dataErrors++;
      $display("mismatch rsp.out (%s): got %h, expected %h", what, got, expected);
    end
  endtask

  task automatic checkError(input string what, input heapError_t got,
                            input heapError_t expected);
    checkCount++;
    if (got !== expected) begin
      errorErrors++;
      $display("mismatch rsp.error (%s): got %h, expected %h", what, got, expected);
    end
  endtask

  `include "heapTests.svh"

  // Watchdog
  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Run stopped after %0d cycles before the tests finished", cycleLimit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    checkCount  = 0;
    dataErrors  = 0;
    errorErrors = 0;
    seed        = 32'h13b3f710;
    reset       = 1'b1;
    cmd.action  = actNone;
    cmd.array   = '0;
    cmd.index   = '0;
    cmd.data    = '0;
    repeat (5) @(posedge clock);                       // Five rising edges in reset
    @(negedge clock);
    reset = 1'b0;
    testAllocation();
    testWriteRead();
    testPushPop();
    testInPlace();
    testBadArrays();
    $display("checks %0d, data mismatches %0d, error mismatches %0d",
             checkCount, dataErrors, errorErrors);
    if (dataErrors == 0 && errorErrors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+sim
common/heapPkg.sv
hw/alloc/arrayAllocator.sv
hw/alloc/sizeTable.sv
hw/store/elementAlu.sv
hw/store/elementStore.sv
hw/commandDecode.sv
hw/heapTop.sv
sim/heapTb.sv
